// ==== build.f ====
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_addr_xlate.sv
rtl/ex_mem_req.sv
rtl/ex_stage.sv
testbench/ex_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module ex_tb \
    -Mdir obj_dir -o ex_tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/ex_tb_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    echo "simulation ok"
    exit 0
else
    echo "simulation reported failures, see sim.log"
    exit 1
fi

// ==== testbench/ex_tb.sv ====
`timescale 1ns/100ps

`include "ex_config.svh"

module ex_tb import ex_pkg::*;
();

    localparam int NUM_PHASES     = 8;
    localparam int PER_PHASE      = 250;
    localparam int NUM_INSTR      = NUM_PHASES * PER_PHASE;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 20;
    localparam int SEED           = 51124;

    logic       clk = 1'b0;
    logic       reset;
    logic       wb_ex;
    logic       ds_valid;
    ds_to_es_t  ds_bus;
    logic       es_allow_in;
    logic       es_to_ms_valid;
    es_to_ms_t  es_to_ms_bus;
    logic       ms_allow_in;
    tlb_req_t   tlb_req;
    tlb_resp_t  tlb_resp;
    asid_t      asid;
    xlate_csr_t csr;
    logic       mem_req_valid;
    mem_req_t   mem_req;
    logic       mem_addr_ok;

    ds_to_es_t pending[$];   // at most one item, the one in the stage
    es_to_ms_t exp_bus;
    mem_req_t  exp_req;
    tlb_req_t  exp_tlb;
    logic      exp_is_mem;
    logic      exp_req_valid;
    logic      exp_valid;
    logic      exp_allow;
    int        cycles = 0;
    int        checks = 0;
    int        errors = 0;
    int        accepted = 0;
    int        transfers = 0;
    int        flushed = 0;

    ex_stage dut_i (.*);

    always #10 clk = ~clk;  // 20 ns period

    // fake tlb entry, every field a function of the vppn
    function automatic tlb_resp_t tlb_entry(input vppn_t vp);
        tlb_resp_t e;
        e.found = vp[0] | vp[1];
        e.v     = vp[1] | vp[2];
        e.d     = vp[2] | vp[3];
        e.plv   = vp[4:3];
        e.ppn   = ppn_t'(vp) ^ 20'h5a5a5;
        return e;
    endfunction

    assign tlb_resp = tlb_entry(tlb_req.vppn);  // answers in the same cycle

    function automatic logic window_hit(input dmw_t w, input plv_t plv, input word_t va);
        return ((plv == 2'd0 && w.plv0) || (plv == 2'd3 && w.plv3)) && va[31:29] == w.vseg;
    endfunction

    task automatic check_eq(input string what, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // reference model of one instruction in the stage
    task automatic predict(input ds_to_es_t b, output es_to_ms_t o, output mem_req_t r,
                           output logic mem_ok);
        word_t     a;
        word_t     c;
        word_t     res;
        word_t     pa;
        tlb_resp_t e;
        logic      is_ld;
        logic      is_st;
        logic      is_word;
        logic      is_half;
        exc_e      x;
        a = b.src1_is_pc ? b.pc : b.rj;
        c = b.src2_is_imm ? b.imm : b.rkd;
        case (b.alu_op)
            alu_add:  res = a + c;
            alu_sub:  res = a - c;
            alu_slt:  res = ($signed(a) < $signed(c)) ? 32'd1 : 32'd0;
            alu_sltu: res = (a < c) ? 32'd1 : 32'd0;
            alu_and:  res = a & c;
            alu_or:   res = a | c;
            alu_xor:  res = a ^ c;
            alu_nor:  res = ~(a | c);
            alu_sll:  res = a << c[4:0];
            alu_srl:  res = a >> c[4:0];
            alu_sra:  res = word_t'($signed(a) >>> c[4:0]);
            default:  res = c;  // lui
        endcase
        is_ld   = b.res_from_mem;
        is_st   = b.mem_we;
        is_word = is_st ? (b.st_op == st_w) : (is_ld && b.ld_op == ld_w);
        is_half = is_st ? (b.st_op == st_h) : (is_ld && (b.ld_op == ld_h || b.ld_op == ld_hu));
        e = tlb_entry(res[31:13]);
        x = exc_none;
        if (csr.da || !csr.pg)
            pa = res;
        else if (window_hit(csr.dmw0, csr.plv, res))
            pa = {csr.dmw0.pseg, res[28:0]};
        else if (window_hit(csr.dmw1, csr.plv, res))
            pa = {csr.dmw1.pseg, res[28:0]};
        else
        begin
            pa = {e.ppn, res[11:0]};
            if (is_ld || is_st)
            begin
                if (csr.plv == 2'd3 && res[31])
                    x = exc_adem;
                else if (!e.found)
                    x = exc_tlbr;
                else if (!e.v)
                    x = is_st ? exc_pis : exc_pil;
                else if (csr.plv > e.plv)
                    x = exc_ppi;
                else if (is_st && !e.d)
                    x = exc_pme;
            end
        end
        if (x == exc_none && ((is_word && pa[1:0] != 2'b00) || (is_half && pa[0])))
            x = exc_ale;
        o.pc           = b.pc;
        o.gr_we        = b.gr_we && x == exc_none;
        o.res_from_mem = is_ld;
        o.mem_we       = is_st;
        o.dest         = b.dest;
        o.result       = res;
        o.vaddr        = res;
        o.addr_low     = pa[1:0];
        o.ld_op        = b.ld_op;
        o.exc          = x;
        r.wr    = is_st;
        r.size  = is_word ? 2'd2 : (is_half ? 2'd1 : 2'd0);
        r.addr  = pa;
        r.wstrb = 4'b0000;
        r.wdata = b.rkd;
        if (is_st && b.st_op == st_w)
            r.wstrb = 4'b1111;
        else if (is_st && b.st_op == st_b)
        begin
            r.wstrb = 4'b0001 << pa[1:0];
            r.wdata = {4{b.rkd[7:0]}};
        end
        else if (is_st && b.st_op == st_h)
        begin
            r.wstrb = pa[1] ? 4'b1100 : 4'b0011;
            r.wdata = {2{b.rkd[15:0]}};
        end
        mem_ok = (is_ld || is_st) && x == exc_none;
    endtask

    function automatic ds_to_es_t random_instr();
        ds_to_es_t b;
        int        kind;
        kind          = int'($urandom % 4);
        b             = '0;
        b.pc          = $urandom;
        b.rj          = $urandom;
        b.rkd         = $urandom;
        b.imm         = $urandom;
        b.dest        = 5'($urandom);
        b.gr_we       = 1'($urandom);
        b.alu_op      = alu_op_e'(4'($urandom % 12));
        b.src1_is_pc  = 1'($urandom);
        b.src2_is_imm = 1'($urandom);
        b.ld_op       = ld_op_e'(3'($urandom % 5));
        b.st_op       = st_op_e'(2'($urandom % 3));
        if (kind >= 2)   // load or store, address is rj plus a small offset
        begin
            b.alu_op       = alu_add;
            b.src1_is_pc   = 1'b0;
            b.src2_is_imm  = 1'b1;
            b.imm          = $urandom & 32'hff;
            b.res_from_mem = (kind == 2);
            b.mem_we       = (kind == 3);
            if ($urandom % 2 != 0)
            begin
                b.rj[1:0]  = 2'b00;   // mostly aligned
                b.imm[1:0] = 2'b00;
            end
        end
        return b;
    endfunction

    task automatic drive_cycle(input logic send);
        ds_valid    = send && ($urandom % 4 != 0);
        ds_bus      = random_instr();
        ms_allow_in = ($urandom % 4) != 0;
        mem_addr_ok = ($urandom % 2) != 0;
        wb_ex       = ($urandom % 64) == 0;   // rare flush
    endtask

    // direct, mapped at plv 0/3, and one da=1 pg=1 phase
    task automatic set_csr(input int phase);
        csr.da   = (phase % 4 == 0);
        csr.pg   = (phase != 0);
        csr.plv  = (phase % 2 != 0) ? 2'd3 : 2'd0;
        if (phase == 7)
            csr.plv = plv_t'($urandom);
        csr.dmw0 = dmw_t'($urandom);
        csr.dmw1 = dmw_t'($urandom);
        asid     = asid_t'($urandom);
    endtask

    // model and compare in mid-cycle when everything has settled
    always @(negedge clk)
    begin
        if (!reset)
        begin
            exp_valid     = 1'b0;
            exp_req_valid = 1'b0;
            if (pending.size() != 0)
            begin
                predict(pending[0], exp_bus, exp_req, exp_is_mem);
                exp_req_valid    = exp_is_mem && ms_allow_in && !wb_ex;
                exp_valid        = !exp_is_mem || (exp_req_valid && mem_addr_ok);
                exp_tlb.vppn     = exp_bus.vaddr[31:13];
                exp_tlb.va_bit12 = exp_bus.vaddr[12];
                exp_tlb.asid     = asid;
                check_eq("tlb_req", 128'(tlb_req), 128'(exp_tlb));
            end
            exp_allow = (pending.size() == 0) || (exp_valid && ms_allow_in);
            check_eq("mem_req_valid", 128'(mem_req_valid), 128'(exp_req_valid));
            check_eq("es_to_ms_valid", 128'(es_to_ms_valid), 128'(exp_valid));
            check_eq("es_allow_in", 128'(es_allow_in), 128'(exp_allow));
            if (mem_req_valid && exp_req_valid)
                check_eq("mem_req", 128'(mem_req), 128'(exp_req));
            if (es_to_ms_valid && exp_valid)
                check_eq("es_to_ms_bus", 128'(es_to_ms_bus), 128'(exp_bus)); // also while held
            if (exp_valid && ms_allow_in)
            begin
                pending.delete(0);
                transfers++;
            end
            else if (wb_ex && pending.size() != 0)
            begin
                pending.delete(0);   // flushed in the stage
                flushed++;
            end
            if (ds_valid && exp_allow && !wb_ex)
            begin
                pending.push_back(ds_bus);
                accepted++;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("test failed");
            $finish;
        end
    end

    initial
    begin
        void'($urandom(SEED));
        reset       = 1'b1;
        wb_ex       = 1'b0;
        ds_valid    = 1'b0;
        ds_bus      = '0;
        ms_allow_in = 1'b0;
        mem_addr_ok = 1'b0;
        csr         = '0;
        asid        = '0;
        set_csr(0);
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_eq("es_to_ms_valid after reset", 128'(es_to_ms_valid), 128'(0));
        check_eq("mem_req_valid after reset", 128'(mem_req_valid), 128'(0));
        check_eq("es_allow_in after reset", 128'(es_allow_in), 128'(1));
        for (int phase = 0; phase < NUM_PHASES; phase++)
        begin
            set_csr(phase);   // stage is empty here
            while (accepted < (phase + 1) * PER_PHASE)
            begin
                @(posedge clk);
                #1 drive_cycle(1'b1);
            end
            do
            begin
                @(posedge clk);
                #1 drive_cycle(1'b0);
            end
            while (pending.size() != 0);
        end
        $display("checks %0d, errors %0d, accepted %0d, transfers %0d, flushed %0d",
                 checks, errors, accepted, transfers, flushed);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// ==== rtl/ex_stage.sv ====
`timescale 1ns/100ps

`include "ex_config.svh"

module ex_stage import ex_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       wb_ex,          // flush from writeback
    input  logic       ds_valid,
    input  ds_to_es_t  ds_bus,
    output logic       es_allow_in,
    output logic       es_to_ms_valid,
    output es_to_ms_t  es_to_ms_bus,
    input  logic       ms_allow_in,
    output tlb_req_t   tlb_req,
    input  tlb_resp_t  tlb_resp,
    input  asid_t      asid,
    input  xlate_csr_t csr,
    output logic       mem_req_valid,
    output mem_req_t   mem_req,
    input  logic       mem_addr_ok
);

    logic      es_valid;
    ds_to_es_t bus_q;
    word_t     alu_result;
    word_t     paddr;
    exc_e      xlate_exc;
    exc_e      exc;
    logic      misaligned;
    logic      is_mem;
    logic      has_exc;
    logic      es_ready_go;

    // one slot; wb_ex kills whatever sits here
    always_ff @(posedge clk)
    begin
        if (reset)
            es_valid <= 1'b0;
        else if (wb_ex)
            es_valid <= 1'b0;
        else if (es_allow_in)
            es_valid <= ds_valid;
    end

    // instruction held in the stage
    always_ff @(posedge clk)
    begin
        if (reset)
            bus_q <= '0;
        else if (ds_valid && es_allow_in)
            bus_q <= ds_bus;
    end

    ex_alu u_alu
    (
        .bus    (bus_q),
        .result (alu_result)
    );

    // tlb port 1 looks up the data address
    assign tlb_req.vppn     = alu_result[`EX_XLEN-1:`EX_PAGE_OFS_W+1];
    assign tlb_req.va_bit12 = alu_result[`EX_PAGE_OFS_W];
    assign tlb_req.asid     = asid;

    ex_addr_xlate u_xlate
    (
        .vaddr    (alu_result),
        .is_load  (es_valid && bus_q.res_from_mem),
        .is_store (es_valid && bus_q.mem_we),
        .csr      (csr),
        .tlb_resp (tlb_resp),
        .paddr    (paddr),
        .exc      (xlate_exc)
    );

    ex_mem_req u_mem_req
    (
        .bus        (bus_q),
        .paddr      (paddr),
        .req        (mem_req),
        .misaligned (misaligned)
    );

    // translation fault outranks alignment
    assign exc     = (xlate_exc != exc_none) ? xlate_exc : (misaligned ? exc_ale : exc_none);
    assign has_exc = (exc != exc_none);
    assign is_mem  = bus_q.res_from_mem || bus_q.mem_we;

    // request only when memory stage can take the result
    assign mem_req_valid = es_valid && is_mem && !has_exc && ms_allow_in && !wb_ex;

    assign es_ready_go    = has_exc || !is_mem || (mem_req_valid && mem_addr_ok);
    assign es_allow_in    = !es_valid || (es_ready_go && ms_allow_in);
    assign es_to_ms_valid = es_valid && es_ready_go;

    assign es_to_ms_bus.pc           = bus_q.pc;
    assign es_to_ms_bus.gr_we        = bus_q.gr_we && !has_exc;  // no writeback on fault
    assign es_to_ms_bus.res_from_mem = bus_q.res_from_mem;
    assign es_to_ms_bus.mem_we       = bus_q.mem_we;
    assign es_to_ms_bus.dest         = bus_q.dest;
    assign es_to_ms_bus.result       = alu_result;
    assign es_to_ms_bus.vaddr        = alu_result;
    assign es_to_ms_bus.addr_low     = paddr[1:0];
    assign es_to_ms_bus.ld_op        = bus_q.ld_op;
    assign es_to_ms_bus.exc          = exc;

    // held output must not move, tlb answer included
    a_hold_stable: assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid && !ms_allow_in && !wb_ex |=> es_to_ms_valid && $stable(es_to_ms_bus))
    else $error("ex_stage: output changed under back-pressure");

    a_alu_op_legal: assert property (@(posedge clk) disable iff (reset)
        es_valid |-> bus_q.alu_op inside {alu_add, alu_sub, alu_slt, alu_sltu,
                                          alu_and, alu_or, alu_xor, alu_nor,
                                          alu_sll, alu_srl, alu_sra, alu_lui})
    else $error("ex_stage: undefined alu_op");

endmodule

// ==== rtl/ex_mem_req.sv ====
`timescale 1ns/100ps

`include "ex_config.svh"

module ex_mem_req import ex_pkg::*;
(
    input  ds_to_es_t bus,
    input  word_t     paddr,
    output mem_req_t  req,
    output logic      misaligned
);

    logic  is_word;
    logic  is_half;
    strb_t wstrb;
    word_t wdata;

    // access width, loads and stores alike
    always_comb
    begin
        is_word = 1'b0;
        is_half = 1'b0;
        if (bus.mem_we)
        begin
            is_word = (bus.st_op == st_w);
            is_half = (bus.st_op == st_h);
        end
        else if (bus.res_from_mem)
        begin
            is_word = (bus.ld_op == ld_w);
            is_half = (bus.ld_op inside {ld_h, ld_hu});
        end
    end

    // lane strobes and replicated store data
    always_comb
    begin
        wstrb = '0;          // loads read the whole word
        wdata = bus.rkd;
        if (bus.mem_we)
        begin
            case (bus.st_op)
                st_w: wstrb = '1;
                st_b:
                begin
                    wstrb = strb_t'(1) << paddr[1:0];
                    wdata = {(`EX_XLEN / 8){bus.rkd[7:0]}};
                end
                st_h:
                begin
                    wstrb = paddr[1] ? 4'b1100 : 4'b0011;  // upper or lower half
                    wdata = {(`EX_XLEN / 16){bus.rkd[15:0]}};
                end
                default: wstrb = '0;
            endcase
        end
    end

    assign misaligned = (is_word && paddr[1:0] != 2'b00) || (is_half && paddr[0]);

    assign req.wr    = bus.mem_we;
    assign req.size  = is_word ? 2'd2 : (is_half ? 2'd1 : 2'd0);
    assign req.wstrb = wstrb;
    assign req.addr  = paddr;
    assign req.wdata = wdata;

    // catches an undefined st_op reaching a store
    always_comb
    begin
        assert final (!bus.mem_we || wstrb != '0)
        else $error("ex_mem_req: store with empty strobe");
    end

endmodule

// ==== rtl/ex_addr_xlate.sv ====
`timescale 1ns/100ps

`include "ex_config.svh"

module ex_addr_xlate import ex_pkg::*;
(
    input  word_t      vaddr,
    input  logic       is_load,
    input  logic       is_store,
    input  xlate_csr_t csr,
    input  tlb_resp_t  tlb_resp,
    output word_t      paddr,
    output exc_e       exc
);

    logic  mapped;    // da=0 pg=1
    logic  hit0;
    logic  hit1;
    logic  page_rt;   // mapped, no window
    logic  access;
    word_t pa_win0;
    word_t pa_win1;
    word_t pa_page;

    // window usable at this plv and segment matches
    function automatic logic dmw_hit(input dmw_t w, input plv_t plv, input word_t va);
        logic plv_ok;
        plv_ok = (plv == plv_t'(0) && w.plv0) || (plv == plv_t'(3) && w.plv3);
        return plv_ok && (va[`EX_XLEN-1 -: `EX_SEG_W] == w.vseg);
    endfunction

    assign mapped  = !csr.da && csr.pg;
    assign hit0    = dmw_hit(csr.dmw0, csr.plv, vaddr);
    assign hit1    = dmw_hit(csr.dmw1, csr.plv, vaddr);
    assign page_rt = mapped && !hit0 && !hit1;
    assign access  = is_load || is_store;

    assign pa_win0 = {csr.dmw0.pseg, vaddr[`EX_XLEN-`EX_SEG_W-1:0]};
    assign pa_win1 = {csr.dmw1.pseg, vaddr[`EX_XLEN-`EX_SEG_W-1:0]};
    assign pa_page = {tlb_resp.ppn, vaddr[`EX_PAGE_OFS_W-1:0]};

    always_comb
    begin
        if (!mapped)
            paddr = vaddr;      // direct, and the odd da/pg combos too
        else if (hit0)
            paddr = pa_win0;    // window 0 has priority
        else if (hit1)
            paddr = pa_win1;
        else
            paddr = pa_page;
    end

    // page route checks, first match wins
    always_comb
    begin
        exc = exc_none;
        if (page_rt && access)
        begin
            if (csr.plv == plv_t'(3) && vaddr[`EX_XLEN-1])
                exc = exc_adem;                    // user touching upper half
            else if (!tlb_resp.found)
                exc = exc_tlbr;
            else if (!tlb_resp.v)
                exc = is_store ? exc_pis : exc_pil;
            else if (csr.plv > tlb_resp.plv)
                exc = exc_ppi;
            else if (is_store && !tlb_resp.d)
                exc = exc_pme;                     // first write to clean page
        end
    end

    // caller decodes load and store from exclusive bits
    always_comb
    begin
        assert final (!(is_load && is_store))
        else $error("ex_addr_xlate: load and store at once");
    end

endmodule

// ==== rtl/ex_alu.sv ====
`timescale 1ns/100ps

module ex_alu import ex_pkg::*;
(
    input  ds_to_es_t bus,
    output word_t     result
);

    word_t      op1;
    word_t      op2;
    logic [4:0] shamt;  // low bits of operand two only

    assign op1   = bus.src1_is_pc  ? bus.pc  : bus.rj;   // pcaddu style uses pc
    assign op2   = bus.src2_is_imm ? bus.imm : bus.rkd;
    assign shamt = op2[4:0];

    always_comb
    begin
        case (bus.alu_op)
            alu_add:  result = op1 + op2;
            alu_sub:  result = op1 - op2;
            alu_slt:  result = word_t'($signed(op1) < $signed(op2));
            alu_sltu: result = word_t'(op1 < op2);
            alu_and:  result = op1 & op2;
            alu_or:   result = op1 | op2;
            alu_xor:  result = op1 ^ op2;
            alu_nor:  result = ~(op1 | op2);
            alu_sll:  result = op1 << shamt;
            alu_srl:  result = op1 >> shamt;
            alu_sra:  result = word_t'($signed(op1) >>> shamt);  // sign fill
            alu_lui:  result = op2;                           // imm already shifted by decode
            default:  result = '0;                            // illegal op, flagged in ex_stage
        endcase
    end

endmodule

// ==== rtl/ex_pkg.sv ====
`include "ex_config.svh"

package ex_pkg;

    typedef logic [`EX_XLEN-1:0]                   word_t;
    typedef logic [`EX_REG_IDX_W-1:0]              reg_idx_t;
    typedef logic [`EX_XLEN-`EX_PAGE_OFS_W-1:0]    ppn_t;     // 20 bits
    typedef logic [`EX_XLEN-`EX_PAGE_OFS_W-2:0]    vppn_t;    // 19 bits, double page
    typedef logic [`EX_SEG_W-1:0]                  seg_t;
    typedef logic [`EX_PLV_W-1:0]                  plv_t;
    typedef logic [`EX_ASID_W-1:0]                 asid_t;
    typedef logic [`EX_STRB_W-1:0]                 strb_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_or, alu_xor, alu_nor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;  // codes 12..15 unused

    typedef enum logic [2:0] {
        exc_none, exc_adem, exc_tlbr, exc_pil,
        exc_pis, exc_ppi, exc_pme, exc_ale
    } exc_e;

    typedef enum logic [2:0] {ld_w, ld_b, ld_bu, ld_h, ld_hu} ld_op_e;
    typedef enum logic [1:0] {st_w, st_b, st_h} st_op_e;

    // one decoded instruction from decode
    typedef struct packed {
        word_t    pc;
        word_t    rj;
        word_t    rkd;          // also store data
        word_t    imm;
        reg_idx_t dest;
        logic     gr_we;
        logic     mem_we;       // store
        logic     res_from_mem; // load
        alu_op_e  alu_op;
        logic     src1_is_pc;
        logic     src2_is_imm;
        ld_op_e   ld_op;
        st_op_e   st_op;
    } ds_to_es_t;

    // handed to the memory stage
    typedef struct packed {
        word_t    pc;
        logic     gr_we;
        logic     res_from_mem;
        logic     mem_we;
        reg_idx_t dest;
        word_t    result;
        word_t    vaddr;        // for badv on a memory exception
        logic [1:0] addr_low;   // byte lane select for load extract
        ld_op_e   ld_op;
        exc_e     exc;
    } es_to_ms_t;

    typedef struct packed {
        logic plv0;   // usable at plv 0
        logic plv3;   // usable at plv 3
        seg_t pseg;
        seg_t vseg;
    } dmw_t;

    typedef struct packed {
        logic da;
        logic pg;
        plv_t plv;
        dmw_t dmw0;
        dmw_t dmw1;
    } xlate_csr_t;

    typedef struct packed {
        vppn_t vppn;
        logic  va_bit12;  // picks even/odd page of the pair
        asid_t asid;
    } tlb_req_t;

    typedef struct packed {
        logic found;
        ppn_t ppn;
        plv_t plv;
        logic d;
        logic v;
    } tlb_resp_t;

    typedef struct packed {
        logic       wr;
        logic [1:0] size;   // 0 byte, 1 half, 2 word
        strb_t      wstrb;
        word_t      addr;
        word_t      wdata;
    } mem_req_t;

endpackage

// ==== rtl/ex_config.svh ====
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// datapath width, one word
`define EX_XLEN 32

// gpr index, 32 registers
`define EX_REG_IDX_W 5

// 4k pages, offset bits below the vppn/ppn split
`define EX_PAGE_OFS_W 12

// direct-mapped window segment, top bits of the address
`define EX_SEG_W 3

// privilege level, 0 most privileged, 3 user
`define EX_PLV_W 2

// address-space id carried to the tlb
`define EX_ASID_W 10

// one strobe bit per byte lane
`define EX_STRB_W (`EX_XLEN / 8)

`endif
